/* Makefile */
# Verilator build and run for the UDP receive path

VERILATOR ?= verilator
FILELIST  ?= udp_rx.f
TB_TOP    ?= udp_rx_tb
RTL_TOP   ?= udp_rx_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# passes only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* rtl/rx_frame_writer.sv */
`timescale 1ns/1ps
module rx_frame_writer (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::payload_beat_t payload,
  input  udp_rx_pkg::src_info_t     src,
  input  logic                      data_almost_full,
  input  logic                      ctrl_almost_full,
  input  logic                      overrun_ack,
  output logic                      data_wr_en,
  output udp_rx_pkg::app_word_t     data_wr,
  output logic                      ctrl_wr_en,
  output udp_rx_pkg::src_info_t     ctrl_wr
);

  typedef enum logic [1:0] {
    st_run,
    st_overrun,
    st_wait_ack
  } state_t;

  state_t state;
  logic   in_frame;
  logic   take;
  logic   near_full;

  assign near_full = data_almost_full || ctrl_almost_full;

  // after an overrun only a frame start is taken, the rest of a frame is skipped
  assign take = (state == st_run) && payload.valid && (payload.first || in_frame);

  assign data_wr_en = take;
  assign ctrl_wr_en = take && payload.first;
  assign ctrl_wr    = src;

  // a word arriving near full becomes the cut, so it closes the frame
  always_comb begin
    data_wr         = payload.word;
    data_wr.eof     = payload.last || near_full;
    data_wr.overrun = near_full;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state    <= st_run;
      in_frame <= 1'b0;
    end else begin
      case (state)
        st_run: begin
          if (take && near_full) begin
            in_frame <= 1'b0;
            state    <= st_overrun;
          end else if (take) begin
            in_frame <= !payload.last;
          end
        end
        // held here until the application answers the overrun
        st_overrun: begin
          if (overrun_ack) begin
            state <= st_wait_ack;
          end
        end
        // let the ack pulse end before writing again
        st_wait_ack: begin
          if (!overrun_ack) begin
            state <= st_run;
          end
        end
        default: state <= st_run;
      endcase
    end
  end

endmodule

/* rtl/rx_sync_fifo.sv */
`timescale 1ns/1ps
module rx_sync_fifo #(
  parameter type entry_t           = logic [7:0],
  parameter int  depth             = 16,
  parameter int  almost_full_level = 12
) (
  input  logic   mac_clk,
  input  logic   mac_rst,
  input  logic   wr_en,
  input  entry_t wr_data,
  input  logic   rd_en,
  output entry_t rd_data,
  output logic   empty,
  output logic   almost_full
);

  entry_t                       mem [depth];
  logic [$clog2(depth)-1:0]     wr_ptr;
  logic [$clog2(depth)-1:0]     rd_ptr;
  logic [$clog2(depth+1)-1:0]   count;
  logic                         full;
  logic                         do_wr;
  logic                         do_rd;

  assign full  = count == ($clog2(depth+1))'(depth);
  assign empty = count == '0;
  assign almost_full = count >= ($clog2(depth+1))'(almost_full_level);

  // writes into a full buffer are lost, pops of an empty one ignored
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // head shown without a read request
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/udp_header_parser.sv */
`timescale 1ns/1ps
module udp_header_parser (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::mac_beat_t     mac_rx,
  input  logic                      phy_rx_up,
  input  udp_rx_pkg::local_cfg_t    local_cfg,
  output udp_rx_pkg::payload_beat_t payload,
  output udp_rx_pkg::src_info_t     src
);

  typedef enum logic [2:0] {
    st_idle,
    st_hdr_2,
    st_hdr_3,
    st_hdr_4,
    st_hdr_5,
    st_hdr_6,
    st_data
  } state_t;

  state_t                state;
  udp_rx_pkg::mac_beat_t beat_z;
  udp_rx_pkg::mac_beat_t beat_r;
  logic                  accept;
  logic                  first_pending;
  logic                  z_end;
  logic                  r_end;
  logic                  frame_start;
  logic                  mac_match;
  logic                  hdr_ok;
  logic                  emit;
  logic [47:0]           dest_mac;
  logic [31:0]           dest_ip;
  logic [15:0]           dest_port;
  logic [63:0]           word_data;
  logic [63:0]           data_q;
  logic                  bad_q;
  logic                  last_q;
  logic                  first_q;
  logic                  valid_q;

  function automatic logic [7:0] get_byte(input logic [63:0] d, input int idx);
    get_byte = d[8*idx +: 8];
  endfunction

  // two beats of history, z is the newest
  always_ff @(posedge mac_clk) begin
    beat_z <= mac_rx;
    beat_r <= beat_z;
  end

  assign z_end = beat_z.good_end | beat_z.bad_end;
  assign r_end = beat_r.good_end | beat_r.bad_end;

  // a one-beat burst is not taken as a frame
  assign frame_start = (beat_z.byte_valid == '1) && phy_rx_up && !z_end;

  assign dest_mac = {get_byte(beat_z.data, 0), get_byte(beat_z.data, 1),
                     get_byte(beat_z.data, 2), get_byte(beat_z.data, 3),
                     get_byte(beat_z.data, 4), get_byte(beat_z.data, 5)};
  // destination IP straddles header beats three and four
  assign dest_ip   = {get_byte(beat_r.data, 6), get_byte(beat_r.data, 7),
                      get_byte(beat_z.data, 0), get_byte(beat_z.data, 1)};
  assign dest_port = {get_byte(beat_z.data, 4), get_byte(beat_z.data, 5)};

  assign mac_match = (dest_mac == local_cfg.mac) || (dest_mac == udp_rx_pkg::BROADCAST_MAC);

  always_comb begin
    case (state)
      st_hdr_2: hdr_ok = ({get_byte(beat_z.data, 4), get_byte(beat_z.data, 5)} ==
                          udp_rx_pkg::ETHERTYPE_IPV4) &&
                         (get_byte(beat_z.data, 6) == udp_rx_pkg::IPV4_VER_IHL);
      st_hdr_3: hdr_ok = get_byte(beat_z.data, 7) == udp_rx_pkg::IP_PROTO_UDP;
      st_hdr_5: hdr_ok = (dest_ip == local_cfg.ip) && (dest_port == local_cfg.port);
      default:  hdr_ok = 1'b1;
    endcase
  end

  // last six bytes of the older beat, then two bytes of the newer one
  always_comb begin
    for (int i = 2; i < udp_rx_pkg::WORD_BYTES; i++) begin
      word_data[8*(udp_rx_pkg::WORD_BYTES + 1 - i) +: 8] = get_byte(beat_r.data, i);
    end
    word_data[15:8] = get_byte(beat_z.data, 0);
    word_data[7:0]  = get_byte(beat_z.data, 1);
  end

  // the final word of a frame leaves one cycle after the state returns to idle
  assign emit = accept && ((state == st_data) || (state == st_idle && r_end));

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state         <= st_idle;
      accept        <= 1'b0;
      first_pending <= 1'b0;
    end else begin
      if (emit) begin
        first_pending <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (r_end) begin
            accept <= 1'b0;
          end
          if (frame_start) begin
            first_pending <= 1'b1;
            accept        <= mac_match;
            state         <= mac_match ? st_hdr_2 : st_data;
          end
        end
        st_hdr_2, st_hdr_3, st_hdr_4, st_hdr_5: begin
          // a frame ending inside the header carries no payload
          if (z_end) begin
            accept <= 1'b0;
            state  <= st_idle;
          end else if (!hdr_ok) begin
            accept <= 1'b0;
            state  <= st_data;
          end else begin
            state <= state_t'(state + 3'd1);
          end
        end
        st_hdr_6: begin
          state <= z_end ? st_idle : st_data;
        end
        st_data: begin
          if (z_end) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      if (!local_cfg.enable) begin
        accept <= 1'b0;
      end
    end
  end

  // source fields, held until the next accepted header
  always_ff @(posedge mac_clk) begin
    if (accept && state == st_hdr_4) begin
      src.ip <= {get_byte(beat_z.data, 2), get_byte(beat_z.data, 3),
                 get_byte(beat_z.data, 4), get_byte(beat_z.data, 5)};
    end
    if (accept && state == st_hdr_5) begin
      src.port <= {get_byte(beat_z.data, 2), get_byte(beat_z.data, 3)};
    end
  end

  always_ff @(posedge mac_clk) begin
    data_q  <= word_data;
    bad_q   <= beat_r.bad_end;
    last_q  <= r_end;
    first_q <= first_pending;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= emit;
    end
  end

  assign payload = '{word:  '{data: data_q, eof: 1'b0, bad: bad_q, overrun: 1'b0},
                     last:  last_q,
                     first: first_q,
                     valid: valid_q};

endmodule

/* rtl/udp_rx_pkg.sv */
package udp_rx_pkg;

  // values the header parser compares against
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
  localparam logic [47:0] BROADCAST_MAC  = {48{1'b1}};

  localparam int WORD_BYTES = 8;

  // buffer sizing, almost full leaves room for the word that trips it
  localparam int DATA_FIFO_DEPTH       = 16;
  localparam int DATA_FIFO_ALMOST_FULL = 12;
  localparam int CTRL_FIFO_DEPTH       = 8;
  localparam int CTRL_FIFO_ALMOST_FULL = 6;

  // byte 0 of the stream sits in data[7:0]
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  byte_valid;
    logic        good_end;
    logic        bad_end;
  } mac_beat_t;

  typedef struct packed {
    logic        enable;
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } local_cfg_t;

  // first payload byte sits in data[63:56]
  typedef struct packed {
    logic [63:0] data;
    logic        eof;
    logic        bad;
    logic        overrun;
  } app_word_t;

  typedef struct packed {
    logic [31:0] ip;
    logic [15:0] port;
  } src_info_t;

  typedef struct packed {
    app_word_t word;
    logic      last;
    logic      first;
    logic      valid;
  } payload_beat_t;

endpackage

/* rtl/udp_rx_top.sv */
`timescale 1ns/1ps
module udp_rx_top (
  input  logic                   mac_clk,
  input  logic                   mac_rst,
  input  udp_rx_pkg::mac_beat_t  mac_rx,
  input  logic                   phy_rx_up,
  input  udp_rx_pkg::local_cfg_t local_cfg,
  output logic                   app_rx_valid,
  output udp_rx_pkg::app_word_t  app_rx_word,
  output udp_rx_pkg::src_info_t  app_rx_src,
  input  logic                   app_rx_ack,
  input  logic                   app_rx_overrun_ack
);

  udp_rx_pkg::payload_beat_t payload;
  udp_rx_pkg::src_info_t     src;
  logic                      data_wr_en;
  udp_rx_pkg::app_word_t     data_wr;
  logic                      data_rd_en;
  logic                      data_empty;
  logic                      data_almost_full;
  logic                      ctrl_wr_en;
  udp_rx_pkg::src_info_t     ctrl_wr;
  logic                      ctrl_rd_en;
  logic                      ctrl_empty;
  logic                      ctrl_almost_full;

  udp_header_parser u_parser (
    .mac_clk   (mac_clk),
    .mac_rst   (mac_rst),
    .mac_rx    (mac_rx),
    .phy_rx_up (phy_rx_up),
    .local_cfg (local_cfg),
    .payload   (payload),
    .src       (src)
  );

  rx_frame_writer u_writer (
    .mac_clk          (mac_clk),
    .mac_rst          (mac_rst),
    .payload          (payload),
    .src              (src),
    .data_almost_full (data_almost_full),
    .ctrl_almost_full (ctrl_almost_full),
    .overrun_ack      (app_rx_overrun_ack),
    .data_wr_en       (data_wr_en),
    .data_wr          (data_wr),
    .ctrl_wr_en       (ctrl_wr_en),
    .ctrl_wr          (ctrl_wr)
  );

  rx_sync_fifo #(
    .entry_t           (udp_rx_pkg::app_word_t),
    .depth             (udp_rx_pkg::DATA_FIFO_DEPTH),
    .almost_full_level (udp_rx_pkg::DATA_FIFO_ALMOST_FULL)
  ) u_data_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (data_wr_en),
    .wr_data     (data_wr),
    .rd_en       (data_rd_en),
    .rd_data     (app_rx_word),
    .empty       (data_empty),
    .almost_full (data_almost_full)
  );

  // one source record per frame, popped along with the eof word
  rx_sync_fifo #(
    .entry_t           (udp_rx_pkg::src_info_t),
    .depth             (udp_rx_pkg::CTRL_FIFO_DEPTH),
    .almost_full_level (udp_rx_pkg::CTRL_FIFO_ALMOST_FULL)
  ) u_ctrl_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     (ctrl_wr),
    .rd_en       (ctrl_rd_en),
    .rd_data     (app_rx_src),
    .empty       (ctrl_empty),
    .almost_full (ctrl_almost_full)
  );

  assign app_rx_valid = !data_empty;
  assign data_rd_en   = app_rx_ack && app_rx_valid;
  assign ctrl_rd_en   = data_rd_en && app_rx_word.eof && !ctrl_empty;

endmodule

/* testbench/udp_rx_clock_gen.sv */
`timescale 1ns/1ps
module udp_rx_clock_gen (
  output logic mac_clk,
  output logic mac_rst
);

  // 100 ns period
  initial begin
    mac_clk = 1'b0;
    forever begin
      #50 mac_clk = ~mac_clk;
    end
  end

  // held for four rising edges, released just after the fourth
  initial begin
    mac_rst = 1'b1;
    repeat (4) @(posedge mac_clk);
    #5 mac_rst = 1'b0;
  end

endmodule

/* testbench/udp_rx_stim.txt */
# T name : test marker
# F dst_mac dst_ip dst_port ethertype ver_ihl proto src_ip src_port beats bad_end enable ack_hold
T unicast
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a63 d431 7 0 1 0
F 021122334455 c0a80a02 1f90 0800 45 11 0a000001 0035 14 0 1 0
F 021122334455 c0a80a02 1f90 0800 45 11 ac100005 c350 6 0 1 0
T broadcast
F ffffffffffff c0a80a02 1f90 0800 45 11 c0a80a07 1234 9 0 1 0
F ffffffffffff c0a80a02 1f90 0800 45 11 c0a80a08 4321 11 0 1 0
T filter
F 021122334466 c0a80a02 1f90 0800 45 11 c0a80a09 1111 8 0 1 0
F 021122334455 c0a80a02 1f90 86dd 45 11 c0a80a09 1112 8 0 1 0
F 021122334455 c0a80a02 1f90 0800 46 11 c0a80a09 1113 8 0 1 0
F 021122334455 c0a80a02 1f90 0800 45 06 c0a80a09 1114 8 0 1 0
F 021122334455 c0a80a03 1f90 0800 45 11 c0a80a09 1115 8 0 1 0
F 021122334455 c0a80a02 1f91 0800 45 11 c0a80a09 1116 8 0 1 0
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a09 1117 8 0 0 0
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a0a 2222 10 0 1 0
T bad_frame
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a0b 3333 9 1 1 0
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a0c 3334 7 0 1 0
T overrun_data
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a21 5001 10 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a22 5002 10 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a23 5003 10 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a24 5004 10 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a25 5005 8 0 1 0
T overrun_ctrl
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a31 6001 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a32 6002 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a33 6003 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a34 6004 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a35 6005 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a36 6006 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a37 6007 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a38 6008 6 0 1 1
F 021122334455 c0a80a02 1f90 0800 45 11 c0a80a39 6009 7 0 1 0

/* testbench/udp_rx_tb.sv */
`timescale 1ns/1ps
module udp_rx_tb;

  typedef struct packed {
    logic [47:0] dmac;
    logic [31:0] dip;
    logic [15:0] dport;
    logic [15:0] etype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    logic [31:0] sip;
    logic [15:0] sport;
    logic [7:0]  beats;
    logic        bad;
    logic        enable;
    logic        hold;
  } frame_rec_t;

  typedef struct packed {
    udp_rx_pkg::app_word_t word;
    udp_rx_pkg::src_info_t src;
  } exp_word_t;

  logic                   mac_clk;
  logic                   mac_rst;
  udp_rx_pkg::mac_beat_t  mac_rx;
  logic                   phy_rx_up;
  udp_rx_pkg::local_cfg_t local_cfg;
  udp_rx_pkg::local_cfg_t home_cfg;
  logic                   app_rx_valid;
  udp_rx_pkg::app_word_t  app_rx_word;
  udp_rx_pkg::src_info_t  app_rx_src;
  logic                   app_rx_ack;
  logic                   app_rx_overrun_ack;

  frame_rec_t recs [0:63];
  logic       is_marker [0:63];
  string      names [0:63];
  int         n_recs;
  int         total_beats;
  int         limit_cycles = 0;
  integer     seed;
  exp_word_t  expected_q [$];
  // occupancy model for frames sent while the application holds off
  int         d_cnt;
  int         c_cnt;
  logic       cut;
  logic       held_pending;
  int         errors;
  int         checks;
  int         tests_run;
  int         tests_failed;
  int         test_err_start;
  string      test_name;

  udp_rx_clock_gen u_clk (
    .mac_clk (mac_clk),
    .mac_rst (mac_rst)
  );

  udp_rx_top dut (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .mac_rx             (mac_rx),
    .phy_rx_up          (phy_rx_up),
    .local_cfg          (local_cfg),
    .app_rx_valid       (app_rx_valid),
    .app_rx_word        (app_rx_word),
    .app_rx_src         (app_rx_src),
    .app_rx_ack         (app_rx_ack),
    .app_rx_overrun_ack (app_rx_overrun_ack)
  );

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    string       tag;
    string       tname;
    logic [47:0] dmac;
    logic [31:0] dip;
    logic [31:0] sip;
    logic [15:0] dport;
    logic [15:0] etype;
    logic [15:0] sport;
    logic [7:0]  verihl;
    logic [7:0]  proto;
    int          beats;
    int          bad;
    int          en;
    int          hold;
    n_recs = 0;
    total_beats = 0;
    fd = $fopen("testbench/udp_rx_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file testbench/udp_rx_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        tag = (line.len() > 1) ? line.substr(0, 0) : "";
        if (tag == "T") begin
          void'($sscanf(line, "T %s", tname));
          names[n_recs] = tname;
          is_marker[n_recs] = 1'b1;
          n_recs++;
        end else if (tag == "F") begin
          n = $sscanf(line, "F %h %h %h %h %h %h %h %h %d %d %d %d", dmac, dip, dport,
                      etype, verihl, proto, sip, sport, beats, bad, en, hold);
          if (n != 12 || beats < 6 || beats > 32) begin
            $display("malformed frame line in stimulus file: %s", line);
            errors++;
          end else begin
            recs[n_recs] = '{dmac, dip, dport, etype, verihl, proto, sip, sport,
                             8'(beats), bad[0], en[0], hold[0]};
            is_marker[n_recs] = 1'b0;
            total_beats += beats;
            n_recs++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic logic frame_accepted(input frame_rec_t rec);
    return (rec.dmac == home_cfg.mac || rec.dmac == udp_rx_pkg::BROADCAST_MAC) &&
           rec.etype == udp_rx_pkg::ETHERTYPE_IPV4 &&
           rec.ver_ihl == udp_rx_pkg::IPV4_VER_IHL &&
           rec.proto == udp_rx_pkg::IP_PROTO_UDP &&
           rec.dip == home_cfg.ip && rec.dport == home_cfg.port && rec.enable;
  endfunction

  task automatic drive_beat(input udp_rx_pkg::mac_beat_t beat);
    @(posedge mac_clk);
    #5;
    mac_rx = beat;
  endtask

  // builds the frame, predicts its words and drives it with three idle beats after
  task automatic send_frame(input frame_rec_t rec);
    logic [7:0]            fb [0:263];
    int                    nbytes;
    int                    nwords;
    exp_word_t             w;
    udp_rx_pkg::mac_beat_t beat;
    nbytes = int'(rec.beats) * 8;
    nwords = int'(rec.beats) - 5;
    for (int i = 0; i < 264; i++) begin
      fb[i] = 8'h00;
    end
    for (int i = 0; i < 6; i++) begin
      fb[i]     = rec.dmac[8*(5-i) +: 8];
      fb[6 + i] = 8'h20 + 8'(i);
    end
    fb[12] = rec.etype[15:8];
    fb[13] = rec.etype[7:0];
    fb[14] = rec.ver_ihl;
    fb[22] = 8'h40;
    fb[23] = rec.proto;
    for (int i = 0; i < 4; i++) begin
      fb[26 + i] = rec.sip[8*(3-i) +: 8];
      fb[30 + i] = rec.dip[8*(3-i) +: 8];
    end
    {fb[34], fb[35]} = rec.sport;
    {fb[36], fb[37]} = rec.dport;
    for (int i = 42; i < nbytes; i++) begin
      fb[i] = 8'($random(seed));
    end
    if (frame_accepted(rec)) begin
      for (int j = 0; j < nwords; j++) begin
        w = '0;
        for (int k = 0; k < 8; k++) begin
          w.word.data[8*(7-k) +: 8] = fb[42 + 8*j + k];
        end
        w.word.eof = (j == nwords - 1);
        w.word.bad = rec.bad && (j == nwords - 1);
        w.src = '{ip: rec.sip, port: rec.sport};
        if (!cut) begin
          // the word that meets an almost full FIFO closes the frame
          if (d_cnt >= udp_rx_pkg::DATA_FIFO_ALMOST_FULL ||
              c_cnt >= udp_rx_pkg::CTRL_FIFO_ALMOST_FULL) begin
            w.word.eof = 1'b1;
            w.word.overrun = 1'b1;
            cut = 1'b1;
          end
          expected_q.push_back(w);
          d_cnt++;
          c_cnt += (j == 0) ? 1 : 0;
        end
      end
    end
    for (int b = 0; b < int'(rec.beats); b++) begin
      beat = '0;
      for (int l = 0; l < 8; l++) begin
        beat.data[8*l +: 8] = fb[8*b + l];
      end
      beat.byte_valid = 8'hff;
      if (b == int'(rec.beats) - 1) begin
        beat.good_end = !rec.bad;
        beat.bad_end  = rec.bad;
      end
      drive_beat(beat);
      if (b == 0) begin
        local_cfg.enable = rec.enable;
      end
    end
    repeat (3) drive_beat('0);
    local_cfg.enable = 1'b1;
  endtask

  // pops the predicted words one per cycle, waiting for each with a timeout
  task automatic collect_words();
    exp_word_t w;
    int        wait_cnt;
    while (expected_q.size() > 0) begin
      w = expected_q.pop_front();
      @(posedge mac_clk);
      #5;
      app_rx_ack = 1'b0;
      wait_cnt = 0;
      while (!app_rx_valid && wait_cnt < 40) begin
        @(posedge mac_clk);
        #5;
        wait_cnt++;
      end
      checks++;
      if (!app_rx_valid) begin
        $display("expected word never arrived, %0d words still missing", expected_q.size() + 1);
        errors++;
        expected_q.delete();
      end else begin
        if (app_rx_word !== w.word || app_rx_src !== w.src) begin
          $display("Error at %0t: word %h src %h, expected %h src %h", $time,
                   app_rx_word, app_rx_src, w.word, w.src);
          errors++;
        end
        app_rx_ack = 1'b1;
      end
    end
    @(posedge mac_clk);
    #5;
    app_rx_ack = 1'b0;
  endtask

  task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge mac_clk);
      #5;
      checks++;
      if (app_rx_valid) begin
        $display("Error at %0t: unexpected word %h in the FIFO", $time, app_rx_word);
        errors++;
      end
    end
  endtask

  // checks what was held back, then releases the writer from overrun
  task automatic drain_held();
    collect_words();
    check_quiet(10);
    if (cut) begin
      app_rx_overrun_ack = 1'b1;
      @(posedge mac_clk);
      #5;
      app_rx_overrun_ack = 1'b0;
    end
    d_cnt = 0;
    c_cnt = 0;
    cut = 1'b0;
    held_pending = 1'b0;
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      tests_run++;
      if (errors > test_err_start) begin
        tests_failed++;
        $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
      end else begin
        $display("test %s: passed", test_name);
      end
    end
    test_err_start = errors;
  endtask

  initial begin
    seed = 32'ha2aba574;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    test_err_start = 0;
    d_cnt = 0;
    c_cnt = 0;
    cut = 1'b0;
    held_pending = 1'b0;
    home_cfg = '{enable: 1'b1, mac: 48'h021122334455, ip: 32'hc0a80a02, port: 16'h1f90};
    mac_rx = '0;
    phy_rx_up = 1'b0;
    local_cfg = home_cfg;
    app_rx_ack = 1'b0;
    app_rx_overrun_ack = 1'b0;
    load_stimulus();
    limit_cycles = total_beats * 4 + 300;
    test_name = "reset";
    wait (!mac_rst);
    phy_rx_up = 1'b1;
    check_quiet(8);
    for (int r = 0; r < n_recs; r++) begin
      if (is_marker[r]) begin
        finish_test();
        test_name = names[r];
      end else begin
        if (!recs[r].hold && held_pending) begin
          drain_held();
        end
        send_frame(recs[r]);
        if (recs[r].hold) begin
          held_pending = 1'b1;
        end else begin
          collect_words();
          check_quiet(10);
          d_cnt = 0;
          c_cnt = 0;
        end
      end
    end
    if (held_pending) begin
      drain_held();
    end
    finish_test();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // limit scales with the number of beats in the stimulus
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge mac_clk);
    $display("watchdog expired after %0d clock cycles before the tests finished", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

/* udp_rx.f */
rtl/udp_rx_pkg.sv
rtl/udp_header_parser.sv
rtl/rx_sync_fifo.sv
rtl/rx_frame_writer.sv
rtl/udp_rx_top.sv
testbench/udp_rx_clock_gen.sv
testbench/udp_rx_tb.sv
